//--- hdl/nl_result_capture.sv
`timescale 1ns/100ps

// folds nonlinear results into new pose and landmark values
module nl_result_capture import slam_pkg::*; (
  input  logic  clk,
  input  logic  sys_rst,
  // done strobes, one cycle each, results valid with them
  input  logic  i_done_predict,
  input  logic  i_done_newlm,
  input  data_t i_result_1,
  input  data_t i_result_2,
  input  data_t i_result_3,
  // current pose from the state bank
  input  data_t i_xk,
  input  data_t i_yk,
  input  data_t i_xita,
  // write strobes, one cycle after done
  output logic  o_pose_we,
  output logic  o_lm_we,
  // updated values for the bank
  output data_t o_x_hat,
  output data_t o_y_hat,
  output data_t o_xita_hat,
  output data_t o_lkx_hat,
  output data_t o_lky_hat
);

  // strobes follow done by one cycle
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      o_pose_we <= 1'b0;
      o_lm_we   <= 1'b0;
    end else begin
      o_pose_we <= i_done_predict;
      o_lm_we   <= i_done_newlm;
    end
  end

  // prediction step
  // result_2 and result_3 are the motion in x and y, result_1 the turn
  always_ff @(posedge clk) begin
    if (i_done_predict) begin
      o_x_hat    <= i_xk + i_result_2;
      o_y_hat    <= i_yk + i_result_3;
      o_xita_hat <= i_xita + i_result_1;
    end
  end

  // new landmark, placed relative to the robot pose
  // note the x offset is result_3 and the y offset result_2 here
  always_ff @(posedge clk) begin
    if (i_done_newlm) begin
      o_lkx_hat <= i_xk + i_result_3;
      o_lky_hat <= i_yk + i_result_2;
    end
  end

endmodule

//--- hdl/slam_pkg.sv
// shared widths and types for the slam state bookkeeping
package slam_pkg;

  // word width of pose, landmark and nonlinear results
  localparam int DATA_W = 32;

  // landmark index width, table depth follows from it
  localparam int LM_IDX_W = 4;
  localparam int LM_NUM = 2 ** LM_IDX_W;

  // stage code width on the processor handshake
  localparam int STAGE_W = 3;

  // one state coordinate or one nonlinear result
  // two's complement, sums wrap in DATA_W bits
  typedef logic signed [DATA_W-1:0] data_t;

  // index into the landmark table
  typedef logic [LM_IDX_W-1:0] lm_idx_t;

  // stage codes shared by stage_val and stage_rdy
  // only PRD and NEW get a launch, UPD and ASSOC are ignored
  typedef enum logic [STAGE_W-1:0] {
    IDLE  = 3'd0,
    PRD   = 3'd1,
    NEW   = 3'd2,
    UPD   = 3'd3,
    ASSOC = 3'd4
  } stage_e;

  // stage controller FSM
  // S_IDLE    waiting for a PRD or NEW code
  // S_LAUNCH  init pulse to the nonlinear unit
  // S_WAIT    waiting for the result write strobe
  // S_REPORT  completion code shown until release
  typedef enum logic [1:0] {
    S_IDLE   = 2'd0,
    S_LAUNCH = 2'd1,
    S_WAIT   = 2'd2,
    S_REPORT = 2'd3
  } ctrl_state_e;

endpackage

//--- hdl/slam_top.sv
`timescale 1ns/100ps

// slam state bookkeeping top
module slam_top import slam_pkg::*; (
  input  logic    clk,
  input  logic    sys_rst,
  // processor handshake
  input  stage_e  i_stage_val,
  input  lm_idx_t i_l_k,
  output stage_e  o_stage_rdy,
  // launch and state towards the nonlinear unit
  output logic    o_init_predict,
  output logic    o_init_newlm,
  output data_t   o_xk,
  output data_t   o_yk,
  output data_t   o_xita,
  output data_t   o_lkx,
  output data_t   o_lky,
  // done and results from the nonlinear unit
  input  logic    i_done_predict,
  input  logic    i_done_newlm,
  input  data_t   i_result_1,
  input  data_t   i_result_2,
  input  data_t   i_result_3
);

  // latched landmark index
  lm_idx_t lm_idx;
  // bank write strobes
  logic    pose_we;
  logic    lm_we;
  // captured values
  data_t   x_hat;
  data_t   y_hat;
  data_t   xita_hat;
  data_t   lkx_hat;
  data_t   lky_hat;

  // stage handshake and launch
  stage_ctrl u_stage_ctrl (
    .clk            (clk),
    .sys_rst        (sys_rst),
    .i_stage_val    (i_stage_val),
    .i_l_k          (i_l_k),
    .o_stage_rdy    (o_stage_rdy),
    .i_pose_we      (pose_we),
    .i_lm_we        (lm_we),
    .o_init_predict (o_init_predict),
    .o_init_newlm   (o_init_newlm),
    .o_lm_idx       (lm_idx)
  );

  // results folded onto the current pose
  nl_result_capture u_nl_result_capture (
    .clk            (clk),
    .sys_rst        (sys_rst),
    .i_done_predict (i_done_predict),
    .i_done_newlm   (i_done_newlm),
    .i_result_1     (i_result_1),
    .i_result_2     (i_result_2),
    .i_result_3     (i_result_3),
    .i_xk           (o_xk),
    .i_yk           (o_yk),
    .i_xita         (o_xita),
    .o_pose_we      (pose_we),
    .o_lm_we        (lm_we),
    .o_x_hat        (x_hat),
    .o_y_hat        (y_hat),
    .o_xita_hat     (xita_hat),
    .o_lkx_hat      (lkx_hat),
    .o_lky_hat      (lky_hat)
  );

  // pose and landmark storage
  state_bank u_state_bank (
    .clk        (clk),
    .sys_rst    (sys_rst),
    .i_pose_we  (pose_we),
    .i_lm_we    (lm_we),
    .i_lm_idx   (lm_idx),
    .i_x_hat    (x_hat),
    .i_y_hat    (y_hat),
    .i_xita_hat (xita_hat),
    .i_lkx_hat  (lkx_hat),
    .i_lky_hat  (lky_hat),
    .o_xk       (o_xk),
    .o_yk       (o_yk),
    .o_xita     (o_xita),
    .o_lkx      (o_lkx),
    .o_lky      (o_lky)
  );

endmodule

//--- hdl/stage_ctrl.sv
`timescale 1ns/100ps

// stage acceptance, launch of the nonlinear unit, completion report
module stage_ctrl import slam_pkg::*; (
  input  logic    clk,
  input  logic    sys_rst,
  // processor side
  // code is a level, held until rdy echoes it
  input  stage_e  i_stage_val,
  input  lm_idx_t i_l_k,
  output stage_e  o_stage_rdy,
  // write strobes from the result capture
  input  logic    i_pose_we,
  input  logic    i_lm_we,
  // launch pulses to the nonlinear unit
  output logic    o_init_predict,
  output logic    o_init_newlm,
  // latched landmark index for the state bank
  output lm_idx_t o_lm_idx
);

  ctrl_state_e state;
  // stage code taken at acceptance
  stage_e      stage_q;
  logic        accept;
  logic        write_done;

  // only prediction and new landmark start a stage
  assign accept = (state == S_IDLE) &&
                  ((i_stage_val == PRD) || (i_stage_val == NEW));

  // either bank write closes the running stage
  assign write_done = i_pose_we | i_lm_we;

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      state    <= S_IDLE;
      stage_q  <= IDLE;
      o_lm_idx <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          // code and index frozen for the whole stage
          if (accept) begin
            state    <= S_LAUNCH;
            stage_q  <= i_stage_val;
            o_lm_idx <= i_l_k;
          end
        end
        S_LAUNCH: begin
          // init is up this cycle only
          if (write_done) begin
            state <= S_REPORT;
          end else begin
            state <= S_WAIT;
          end
        end
        S_WAIT: begin
          // strobe comes one cycle after done
          // bank takes the write at the same edge
          if (write_done) begin
            state <= S_REPORT;
          end
        end
        S_REPORT: begin
          // processor drops the code back to idle
          if (i_stage_val == IDLE) begin
            state <= S_IDLE;
          end
        end
        default: begin
          state <= S_IDLE;
        end
      endcase
    end
  end

  // one cycle launch, picked by the latched code
  assign o_init_predict = (state == S_LAUNCH) && (stage_q == PRD);
  assign o_init_newlm   = (state == S_LAUNCH) && (stage_q == NEW);

  // completion code while reporting, idle otherwise
  assign o_stage_rdy = (state == S_REPORT) ? stage_q : IDLE;

endmodule

//--- hdl/state_bank.sv
`timescale 1ns/100ps

// robot pose and landmark table held in flops
module state_bank import slam_pkg::*; (
  input  logic    clk,
  input  logic    sys_rst,
  // write strobes from the result capture
  input  logic    i_pose_we,
  input  logic    i_lm_we,
  // landmark entry for both read and write
  input  lm_idx_t i_lm_idx,
  // new pose
  input  data_t   i_x_hat,
  input  data_t   i_y_hat,
  input  data_t   i_xita_hat,
  // new landmark position
  input  data_t   i_lkx_hat,
  input  data_t   i_lky_hat,
  // current pose
  output data_t   o_xk,
  output data_t   o_yk,
  output data_t   o_xita,
  // current landmark at i_lm_idx
  output data_t   o_lkx,
  output data_t   o_lky
);

  // pose registers
  data_t xk_q;
  data_t yk_q;
  data_t xita_q;

  // landmark table, x and y per entry
  data_t lm_x [0:LM_NUM-1];
  data_t lm_y [0:LM_NUM-1];

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      // whole map starts at the origin
      xk_q   <= '0;
      yk_q   <= '0;
      xita_q <= '0;
      for (int i = 0; i < LM_NUM; i++) begin
        lm_x[i] <= '0;
        lm_y[i] <= '0;
      end
    end else begin
      // pose replaced as a whole
      if (i_pose_we) begin
        xk_q   <= i_x_hat;
        yk_q   <= i_y_hat;
        xita_q <= i_xita_hat;
      end
      // single entry write, rest untouched
      if (i_lm_we) begin
        lm_x[i_lm_idx] <= i_lkx_hat;
        lm_y[i_lm_idx] <= i_lky_hat;
      end
    end
  end

  // reads straight from the registers
  assign o_xk   = xk_q;
  assign o_yk   = yk_q;
  assign o_xita = xita_q;

  // table read at the latched index
  assign o_lkx = lm_x[i_lm_idx];
  assign o_lky = lm_y[i_lm_idx];

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the slam testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sources.f --top-module tb_slam_top -o sim_slam \
  && ./obj_dir/sim_slam > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
grep -q "TESTBENCH FAILED" sim.log && { echo "simulation failed"; exit 1; } \
  || { echo "simulation passed"; exit 0; }

//--- sources.f
hdl/slam_pkg.sv
hdl/stage_ctrl.sv
hdl/nl_result_capture.sv
hdl/state_bank.sv
hdl/slam_top.sv
test/slam_checker.sv
test/tb_slam_top.sv

//--- test/slam_checker.sv
`timescale 1ns/100ps

// reference model of pose and landmark table, compares DUT outputs
module slam_checker import slam_pkg::*; (
  input logic    clk,
  input logic    sys_rst,
  // processor handshake as seen on the DUT ports
  input lm_idx_t i_l_k,
  input stage_e  i_stage_rdy,
  // launch pulses
  input logic    i_init_predict,
  input logic    i_init_newlm,
  // nonlinear unit answer
  input logic    i_done_predict,
  input logic    i_done_newlm,
  input data_t   i_result_1,
  input data_t   i_result_2,
  input data_t   i_result_3,
  // state outputs under test
  input data_t   i_xk,
  input data_t   i_yk,
  input data_t   i_xita,
  input data_t   i_lkx,
  input data_t   i_lky
);

  // set by the testbench before each test
  string   test_name = "none";
  int      err_count = 0;
  int      check_count = 0;
  // launch pulses seen so far
  int      predict_pulses = 0;
  int      newlm_pulses = 0;

  // model state
  data_t   m_xk;
  data_t   m_yk;
  data_t   m_xita;
  data_t   m_lx [0:LM_NUM-1];
  data_t   m_ly [0:LM_NUM-1];
  lm_idx_t m_idx;
  // stage_rdy seen at the previous edge
  stage_e  rdy_q;

  // one value against its expectation
  task automatic compare(input string what, input data_t exp, input data_t act);
    check_count++;
    if (exp !== act) begin
      err_count++;
      $display("FAILED %s: %s expected %0d actual %0d", test_name, what, exp, act);
    end
  endtask

  // pose and the landmark at the latched index
  task automatic compare_state();
    compare("xk", m_xk, i_xk);
    compare("yk", m_yk, i_yk);
    compare("xita", m_xita, i_xita);
    compare("lkx", m_lx[m_idx], i_lkx);
    compare("lky", m_ly[m_idx], i_lky);
  endtask

  always @(posedge clk) begin
    if (sys_rst) begin
      m_xk   = '0;
      m_yk   = '0;
      m_xita = '0;
      for (int i = 0; i < LM_NUM; i++) begin
        m_lx[i] = '0;
        m_ly[i] = '0;
      end
      m_idx = '0;
      rdy_q = IDLE;
    end else begin
      if (i_init_predict) begin
        predict_pulses++;
      end
      if (i_init_newlm) begin
        newlm_pulses++;
      end
      // index is still held by the processor at launch time
      if (i_init_predict || i_init_newlm) begin
        m_idx = i_l_k;
      end
      // motion step, x from result_2, y from result_3, heading from result_1
      if (i_done_predict) begin
        m_xk   = m_xk + i_result_2;
        m_yk   = m_yk + i_result_3;
        m_xita = m_xita + i_result_1;
      end
      // landmark placed on the current pose, offsets swapped
      if (i_done_newlm) begin
        m_lx[m_idx] = m_xk + i_result_3;
        m_ly[m_idx] = m_yk + i_result_2;
      end
      // stage finished, bank already written
      if (rdy_q == IDLE && i_stage_rdy != IDLE) begin
        compare_state();
      end
      rdy_q = i_stage_rdy;
    end
  end

endmodule

//--- test/tb_slam_top.sv
`timescale 1ns/100ps

// testbench for the slam state bookkeeping top
module tb_slam_top import slam_pkg::*; ();

  // cycles any single wait may take
  localparam int TIMEOUT = 200;

  logic    clk = 1'b0;
  logic    sys_rst;
  stage_e  stage_val;
  lm_idx_t l_k;
  stage_e  stage_rdy;
  logic    init_predict;
  logic    init_newlm;
  data_t   xk;
  data_t   yk;
  data_t   xita;
  data_t   lkx;
  data_t   lky;
  logic    done_predict;
  logic    done_newlm;
  data_t   result_1;
  data_t   result_2;
  data_t   result_3;

  int tests_run = 0;
  int tests_failed = 0;
  int errs_before = 0;

  // 40 ns period
  always #20 clk = ~clk;

  slam_top uut (
    .clk            (clk),
    .sys_rst        (sys_rst),
    .i_stage_val    (stage_val),
    .i_l_k          (l_k),
    .o_stage_rdy    (stage_rdy),
    .o_init_predict (init_predict),
    .o_init_newlm   (init_newlm),
    .o_xk           (xk),
    .o_yk           (yk),
    .o_xita         (xita),
    .o_lkx          (lkx),
    .o_lky          (lky),
    .i_done_predict (done_predict),
    .i_done_newlm   (done_newlm),
    .i_result_1     (result_1),
    .i_result_2     (result_2),
    .i_result_3     (result_3)
  );

  slam_checker chk (
    .clk            (clk),
    .sys_rst        (sys_rst),
    .i_l_k          (l_k),
    .i_stage_rdy    (stage_rdy),
    .i_init_predict (init_predict),
    .i_init_newlm   (init_newlm),
    .i_done_predict (done_predict),
    .i_done_newlm   (done_newlm),
    .i_result_1     (result_1),
    .i_result_2     (result_2),
    .i_result_3     (result_3),
    .i_xk           (xk),
    .i_yk           (yk),
    .i_xita         (xita),
    .i_lkx          (lkx),
    .i_lky          (lky)
  );

  // mostly random, now and then at the signed limits
  function automatic data_t rand_result();
    case ($urandom_range(0, 7))
      0: return 32'sh7fff_ffff;
      1: return 32'sh8000_0000;
      default: return $urandom;
    endcase
  endfunction

  // nonlinear unit stand-in, one done per launch after 1 to 8 cycles
  always begin : nl_responder
    int   delay;
    logic is_predict;
    @(posedge clk);
    if (!sys_rst && (init_predict || init_newlm)) begin
      is_predict = init_predict;
      delay = $urandom_range(1, 8);
      repeat (delay) @(posedge clk);
      #1;
      done_predict = is_predict;
      done_newlm   = !is_predict;
      result_1     = rand_result();
      result_2     = rand_result();
      result_3     = rand_result();
      @(posedge clk);
      #1;
      done_predict = 1'b0;
      done_newlm   = 1'b0;
    end
  end

  task automatic abort_on_timeout(input string what);
    $display("timeout after %0d cycles while %s", TIMEOUT, what);
    $display("TESTBENCH FAILED");
    $finish;
  endtask

  task automatic wait_for_rdy(input stage_e code, input string what);
    int cycles;
    cycles = 0;
    while (stage_rdy !== code && cycles < TIMEOUT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (stage_rdy !== code) begin
      abort_on_timeout(what);
    end
  endtask

  // full handshake, request held for extra cycles after the report
  task automatic run_stage(input stage_e code, input lm_idx_t idx, input int hold);
    stage_val = code;
    l_k       = idx;
    wait_for_rdy(code, "waiting for the stage to report done");
    repeat (hold) begin
      @(posedge clk);
      #1;
      chk.compare("stage_rdy while held", data_t'(code), data_t'(stage_rdy));
    end
    stage_val = IDLE;
    wait_for_rdy(IDLE, "waiting for stage_rdy to return to idle");
  endtask

  // random index, one launch of the matching kind only
  task automatic stage_with_pulse_check(input stage_e code, input int hold);
    int      pred_before;
    int      newlm_before;
    lm_idx_t idx;
    pred_before  = chk.predict_pulses;
    newlm_before = chk.newlm_pulses;
    idx = lm_idx_t'($urandom_range(0, LM_NUM - 1));
    run_stage(code, idx, hold);
    chk.compare("init_predict pulses", pred_before + ((code == PRD) ? 1 : 0),
                chk.predict_pulses);
    chk.compare("init_newlm pulses", newlm_before + ((code == NEW) ? 1 : 0),
                chk.newlm_pulses);
  endtask

  // UPD and ASSOC must be left alone
  task automatic ignored_code_check(input stage_e code);
    int pred_before;
    int newlm_before;
    pred_before  = chk.predict_pulses;
    newlm_before = chk.newlm_pulses;
    stage_val = code;
    repeat (50) begin
      @(posedge clk);
      #1;
      chk.compare("stage_rdy on ignored code", data_t'(IDLE), data_t'(stage_rdy));
    end
    stage_val = IDLE;
    chk.compare("init_predict pulses", pred_before, chk.predict_pulses);
    chk.compare("init_newlm pulses", newlm_before, chk.newlm_pulses);
  endtask

  task automatic start_test(input string name);
    chk.test_name = name;
    errs_before = chk.err_count;
  endtask

  task automatic end_test();
    int errs;
    errs = chk.err_count - errs_before;
    tests_run++;
    if (errs == 0) begin
      $display("PASSED %s", chk.test_name);
    end else begin
      tests_failed++;
      $display("FAILED %s: expected 0 mismatches, actual %0d", chk.test_name, errs);
    end
  endtask

  initial begin
    void'($urandom(32'h6bff_afcc));
    sys_rst      = 1'b1;
    stage_val    = IDLE;
    l_k          = '0;
    done_predict = 1'b0;
    done_newlm   = 1'b0;
    result_1     = '0;
    result_2     = '0;
    result_3     = '0;
    repeat (16) @(posedge clk);
    #1;
    sys_rst = 1'b0;

    // everything cleared, whatever index is driven
    start_test("reset state");
    for (int i = 0; i < LM_NUM; i++) begin
      l_k = lm_idx_t'(i);
      @(posedge clk);
      #1;
      chk.compare("stage_rdy", data_t'(IDLE), data_t'(stage_rdy));
      chk.compare("init_predict", 0, data_t'(init_predict));
      chk.compare("init_newlm", 0, data_t'(init_newlm));
      chk.compare_state();
    end
    end_test();

    start_test("prediction stage");
    stage_with_pulse_check(PRD, 0);
    end_test();

    // later predictions read other entries of the table
    start_test("new landmark stage");
    stage_with_pulse_check(NEW, 0);
    repeat (6) stage_with_pulse_check(PRD, 0);
    end_test();

    start_test("hold and release");
    stage_with_pulse_check(PRD, $urandom_range(5, 20));
    stage_with_pulse_check(NEW, $urandom_range(5, 20));
    end_test();

    start_test("ignored codes");
    ignored_code_check(UPD);
    ignored_code_check(ASSOC);
    end_test();

    start_test("random stages");
    for (int n = 0; n < 200; n++) begin
      stage_with_pulse_check(($urandom_range(0, 1) == 0) ? PRD : NEW, $urandom_range(0, 3));
    end
    end_test();

    $display("tests run %0d, failed %0d, checks %0d, mismatches %0d",
             tests_run, tests_failed, chk.check_count, chk.err_count);
    if (tests_failed == 0 && chk.err_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
